// ==== sim.f ====
+incdir+include
design/icache_pkg.sv
design/refill_if.sv
design/cache_ram.sv
design/icache_ctrl.sv
design/icache_refill.sv
design/icache_top.sv
testbench/icache_asserts.sv
testbench/icache_tb.sv

// ==== testbench/icache_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "icache_cfg.svh"

module icache_tb;

    localparam int TIMEOUT = 200;  // Cycles per wait
    localparam int BLK     = `ICACHE_BLOCK_WORDS;

    typedef struct {
        logic [31:0] addr;
        logic        hit;
        int          mem_start;
        int          req_cycle;
    } fetch_rec_t;

    logic        Clk, rst_n, flush, fetch_req, fetch_ack, mem_req, mem_ack;
    logic [31:0] fetch_addr, fetch_data, mem_addr, mem_data;

    logic [31:0] stim_lfsr, mem_lfsr;
    int          cycle, mem_count, errors, fetches, pred_hits, dut_hits;
    logic        ack_prev;
    fetch_rec_t  pending_q[$];
    logic [31:0] mem_log[$];

    // Shadow of the tag store
    logic                     sh_valid [`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS];
    logic [`ICACHE_TAG_W-1:0] sh_tag   [`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS];
    int                       sh_rr    [`ICACHE_NUM_SETS];

    icache_top UUT (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_ack  (fetch_ack),
        .fetch_data (fetch_data),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_ack    (mem_ack),
        .mem_data   (mem_data)
    );

    always #5 Clk = ~Clk;

    always @(posedge Clk) cycle++;

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v     = {v[30:0], state[0]};
            state = galois_step(state);
        end
        return v;
    endfunction

    // Memory contents as a function of the byte address
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] w;
        w = a * 32'h9e3779b1;
        w = w ^ (w >> 15);
        return w ^ 32'h5a5a0f0f;
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
        return (tag << (`ICACHE_SET_W + `ICACHE_OFFS_W)) | (set << `ICACHE_OFFS_W)
               | (word << `ICACHE_BYTE_W);
    endfunction

    function automatic void clear_shadow();
        for (int s = 0; s < `ICACHE_NUM_SETS; s++) begin
            for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
                sh_valid[s][w] = 1'b0;
            end
        end
    endfunction

    // Predicts hit or miss and installs the line on a miss
    function automatic logic expected_fetch(input logic [31:0] a);
        int                       s, victim;
        logic [`ICACHE_TAG_W-1:0] t;
        s = (a >> `ICACHE_OFFS_W) % `ICACHE_NUM_SETS;
        t = a >> (`ICACHE_SET_W + `ICACHE_OFFS_W);
        for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
            if (sh_valid[s][w] && sh_tag[s][w] == t) return 1'b1;
        end
        victim = -1;
        for (int w = `ICACHE_NUM_WAYS - 1; w >= 0; w--) begin
            if (!sh_valid[s][w]) victim = w;  // Lowest free way
        end
        if (victim < 0) begin
            victim   = sh_rr[s];
            sh_rr[s] = (sh_rr[s] + 1) % `ICACHE_NUM_WAYS;
        end
        sh_valid[s][victim] = 1'b1;
        sh_tag[s][victim]   = t;
        return 1'b0;
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("Timeout waiting for %s", what);
        $display("=== FAIL ===");
        $finish;
    endtask

    // Memory side, one handshake per word
    always begin : mem_model
        int delay;
        int n;
        @(posedge Clk);
        #1;
        if (rst_n && mem_req) begin
            delay = take_bits(mem_lfsr, 2);
            repeat (delay) begin
                @(posedge Clk);
                #1;
            end
            mem_data = mem_word(mem_addr);
            mem_ack  = 1'b1;
            mem_count++;
            mem_log.push_back(mem_addr);
            n = 0;
            while (mem_req && n < TIMEOUT) begin
                @(posedge Clk);
                #1;
                n++;
            end
            if (mem_req) abort_on_timeout("mem_req to drop");
            mem_ack = 1'b0;
        end
    end

    // Compares each response against the prediction made at issue time
    always @(posedge Clk) begin : response_check
        fetch_rec_t  rec;
        logic [31:0] base;
        logic [31:0] got;
        logic [31:0] exp_data;
        int          lat;
        #1;
        if (fetch_ack && !ack_prev) begin
            assert (pending_q.size() != 0) else begin
                $error("fetch_ack rose with no fetch outstanding");
                errors++;
            end
            if (pending_q.size() != 0) begin
                rec      = pending_q.pop_front();
                exp_data = mem_word(rec.addr);
                assert (mem_count - rec.mem_start == (rec.hit ? 0 : BLK)) else begin
                    $error("Error mem handshakes: got %h, expected %h",
                           mem_count - rec.mem_start, rec.hit ? 0 : BLK);
                    errors++;
                end
                if (mem_count == rec.mem_start) dut_hits++;
                lat = cycle - rec.req_cycle - 1;  // From the edge that samples fetch_req
                if (rec.hit) begin
                    assert (lat == 2) else begin
                        $error("Hit on %h acknowledged after %0d cycles instead of 2",
                               rec.addr, lat);
                        errors++;
                    end
                end
                base = (rec.addr >> `ICACHE_OFFS_W) << `ICACHE_OFFS_W;
                for (int i = 0; i < BLK && !rec.hit && mem_log.size() != 0; i++) begin
                    got = mem_log.pop_front();
                    assert (got == base + i * (`ICACHE_WORD_W / 8)) else begin
                        $error("Error mem_addr: got %h, expected %h", got,
                               base + i * (`ICACHE_WORD_W / 8));
                        errors++;
                    end
                end
                mem_log.delete();
            end
        end
        // Word held for as long as fetch_ack is high
        if (fetch_ack) begin
            assert (fetch_data == exp_data) else begin
                $error("Error fetch_data: got %h, expected %h", fetch_data, exp_data);
                errors++;
            end
        end
        ack_prev = fetch_ack;
    end

    task automatic do_fetch(input logic [31:0] a, input int hold, input logic flush_mid);
        fetch_rec_t rec;
        int         n;
        logic       flush_done;
        rec.addr      = a;
        rec.hit       = expected_fetch(a);
        rec.mem_start = mem_count;
        rec.req_cycle = cycle;
        pending_q.push_back(rec);
        pred_hits += rec.hit;
        fetches++;
        fetch_addr = a;
        fetch_req  = 1'b1;
        n          = 0;
        flush_done = 1'b0;
        while (!fetch_ack && n < TIMEOUT) begin
            @(posedge Clk);
            #1;
            n++;
            flush      = flush_mid && mem_req && !flush_done;  // One pulse inside the refill
            flush_done = flush_done || flush;
        end
        if (!fetch_ack) abort_on_timeout($sformatf("fetch_ack on %h", a));
        if (flush_mid) clear_shadow();  // Deferred flush runs after this miss
        repeat (hold) begin
            @(posedge Clk);
            #1;
        end
        fetch_req = 1'b0;
        n = 0;
        while (fetch_ack && n < TIMEOUT) begin
            @(posedge Clk);
            #1;
            n++;
        end
        if (fetch_ack) abort_on_timeout("fetch_ack to drop");
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(posedge Clk);
        #1;
        flush = 1'b0;
        clear_shadow();
    endtask

    task automatic end_test(input string name, input int err_mark, input int fetch_mark);
        $display("Test %s: %0d fetches, %0d errors", name, fetches - fetch_mark,
                 errors - err_mark);
    endtask

    initial begin : main
        int err_mark;
        int fetch_mark;
        int hit_mark;
        int pred_mark;
        Clk        = 1'b0;
        rst_n      = 1'b0;
        flush      = 1'b0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        mem_ack    = 1'b0;
        mem_data   = '0;
        ack_prev   = 1'b0;
        stim_lfsr  = 32'h6695ae6d;
        mem_lfsr   = 32'h6695ae6d;
        for (int s = 0; s < `ICACHE_NUM_SETS; s++) sh_rr[s] = 0;
        clear_shadow();
        repeat (2) @(posedge Clk);
        #1;
        rst_n = 1'b1;

        err_mark   = errors;
        fetch_mark = fetches;
        do_fetch(make_addr(5, 2, 1), 0, 1'b0);
        for (int w = 0; w < BLK; w++) begin
            if (w != 1) do_fetch(make_addr(5, 2, w), 0, 1'b0);
        end
        end_test("1 cold miss then hit", err_mark, fetch_mark);

        // Five lines on set 5, then the survivors and the evicted one
        err_mark   = errors;
        fetch_mark = fetches;
        for (int t = 16; t < 20; t++) do_fetch(make_addr(t, 5, 0), 0, 1'b0);
        for (int t = 16; t < 20; t++) do_fetch(make_addr(t, 5, 3), 1, 1'b0);
        do_fetch(make_addr(20, 5, 0), 0, 1'b0);
        for (int t = 17; t < 20; t++) do_fetch(make_addr(t, 5, 1), 0, 1'b0);
        do_fetch(make_addr(16, 5, 2), 0, 1'b0);
        end_test("2 ways filling", err_mark, fetch_mark);

        err_mark   = errors;
        fetch_mark = fetches;
        for (int t = 21; t < 24; t++) do_fetch(make_addr(t, 5, 0), 0, 1'b0);
        for (int t = 16; t < 24; t++) do_fetch(make_addr(t, 5, 2), 0, 1'b0);
        end_test("3 round robin", err_mark, fetch_mark);

        err_mark   = errors;
        fetch_mark = fetches;
        pulse_flush();
        do_fetch(make_addr(5, 2, 1), 0, 1'b0);
        do_fetch(make_addr(23, 5, 0), 0, 1'b0);
        do_fetch(make_addr(9, 3, 2), 2, 1'b1);
        do_fetch(make_addr(9, 3, 2), 0, 1'b0);
        end_test("4 flush", err_mark, fetch_mark);

        // Random addresses in a 1 KB window, eight tags per set
        err_mark   = errors;
        fetch_mark = fetches;
        hit_mark   = dut_hits;
        pred_mark  = pred_hits;
        for (int i = 0; i < 300; i++) begin
            do_fetch(take_bits(stim_lfsr, 8) << 2, take_bits(stim_lfsr, 2), 1'b0);
        end
        assert (dut_hits - hit_mark == pred_hits - pred_mark) else begin
            $error("Error hit count: got %h, expected %h", dut_hits - hit_mark,
                   pred_hits - pred_mark);
            errors++;
        end
        end_test("5 random run", err_mark, fetch_mark);

        errors += UUT.u_asserts.failures;
        $display("Totals: %0d fetches, %0d hits, %0d misses, %0d errors", fetches,
                 dut_hits, fetches - dut_hits, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/icache_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

// Handshake rules on the top-level ports of the cache
module icache_asserts (
    input wire logic        Clk,
    input wire logic        rst_n,
    input wire logic        fetch_req,
    input wire logic [31:0] fetch_addr,
    input wire logic        fetch_ack,
    input wire logic        mem_req,
    input wire logic [31:0] mem_addr
);

    int failures = 0;  // Assertion failures so far

    // Core holds the request until the cache answers
    req_held: assert property (@(posedge Clk) disable iff (!rst_n)
        $past(fetch_req) && !fetch_ack |-> fetch_req && $stable(fetch_addr))
        else begin
            $error("fetch_req or fetch_addr changed before fetch_ack");
            failures++;
        end

    mem_addr_held: assert property (@(posedge Clk) disable iff (!rst_n)
        mem_req && $past(mem_req) |-> $stable(mem_addr))
        else begin
            $error("mem_addr changed while mem_req was high");
            failures++;
        end

    // No refill traffic once the response is up
    no_mem_in_resp: assert property (@(posedge Clk) disable iff (!rst_n)
        fetch_ack |-> !mem_req)
        else begin
            $error("mem_req high during a fetch response");
            failures++;
        end

    // Request seen at the edge that raised the ack
    ack_needs_req: assert property (@(posedge Clk) disable iff (!rst_n)
        $rose(fetch_ack) |-> $past(fetch_req))
        else begin
            $error("fetch_ack rose without fetch_req");
            failures++;
        end

endmodule

bind icache_top icache_asserts u_asserts (
    .Clk        (Clk),
    .rst_n      (rst_n),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .fetch_ack  (fetch_ack),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr)
);

`default_nettype wire

// ==== design/icache_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "icache_cfg.svh"

module icache_top (
    input  logic                      Clk,
    input  logic                      rst_n,
    input  logic                      flush,
    input  logic                      fetch_req,
    input  logic [`ICACHE_ADDR_W-1:0] fetch_addr,
    output logic                      fetch_ack,
    output logic [`ICACHE_WORD_W-1:0] fetch_data,
    output logic                      mem_req,
    output logic [`ICACHE_ADDR_W-1:0] mem_addr,
    input  logic                      mem_ack,
    input  logic [`ICACHE_WORD_W-1:0] mem_data
);

    icache_pkg::set_idx_t  tag_addr;
    logic                  tag_we;
    icache_pkg::tag_set_t  tag_wdata;
    icache_pkg::tag_set_t  tag_rdata;
    icache_pkg::set_idx_t  data_addr;
    logic                  data_we;
    icache_pkg::data_set_t data_wdata;
    icache_pkg::data_set_t data_rdata;

    refill_if rf_bus ();

    icache_ctrl u_ctrl (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_ack  (fetch_ack),
        .fetch_data (fetch_data),
        .tag_addr   (tag_addr),
        .tag_we     (tag_we),
        .tag_wdata  (tag_wdata),
        .tag_rdata  (tag_rdata),
        .data_addr  (data_addr),
        .data_we    (data_we),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .rf         (rf_bus.ctrl)
    );

    // Valid bits and tags of all ways
    cache_ram #(
        .ENTRY_T (icache_pkg::tag_set_t),
        .DEPTH   (`ICACHE_NUM_SETS)
    ) u_tag_ram (
        .Clk   (Clk),
        .addr  (tag_addr),
        .we    (tag_we),
        .wdata (tag_wdata),
        .rdata (tag_rdata)
    );

    // Line data of all ways
    cache_ram #(
        .ENTRY_T (icache_pkg::data_set_t),
        .DEPTH   (`ICACHE_NUM_SETS)
    ) u_data_ram (
        .Clk   (Clk),
        .addr  (data_addr),
        .we    (data_we),
        .wdata (data_wdata),
        .rdata (data_rdata)
    );

    icache_refill u_refill (
        .Clk      (Clk),
        .rst_n    (rst_n),
        .rf       (rf_bus.refill),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .mem_ack  (mem_ack),
        .mem_data (mem_data)
    );

endmodule

`default_nettype wire

// ==== design/icache_refill.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "icache_cfg.svh"

// Fetches one line from memory, one handshake per word
module icache_refill (
    input  logic                      Clk,
    input  logic                      rst_n,
    refill_if.refill                  rf,
    output logic                      mem_req,
    output logic [`ICACHE_ADDR_W-1:0] mem_addr,
    input  logic                      mem_ack,
    input  icache_pkg::word_t         mem_data
);

    icache_pkg::refill_state_t state;
    icache_pkg::word_idx_t     cnt;
    icache_pkg::line_t         line_buf;

    // Counter only moves while mem_req is low
    assign mem_addr = {rf.line_addr[`ICACHE_ADDR_W-1:`ICACHE_OFFS_W], cnt,
                       {(`ICACHE_BYTE_W){1'b0}}};
    assign rf.line  = line_buf;

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            state   <= icache_pkg::R_IDLE;
            cnt     <= '0;
            mem_req <= 1'b0;
            rf.ack  <= 1'b0;
        end else begin
            case (state)
                icache_pkg::R_IDLE: begin
                    if (rf.req && !mem_ack) begin  // Previous ack must be gone
                        cnt     <= '0;
                        mem_req <= 1'b1;
                        state   <= icache_pkg::R_REQ;
                    end
                end
                icache_pkg::R_REQ: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        if (cnt == icache_pkg::word_idx_t'(`ICACHE_BLOCK_WORDS - 1)) begin
                            state <= icache_pkg::R_LAST;
                        end else begin
                            state <= icache_pkg::R_REL;
                        end
                    end
                end
                icache_pkg::R_REL: begin
                    if (!mem_ack) begin
                        cnt     <= cnt + 1'b1;
                        mem_req <= 1'b1;
                        state   <= icache_pkg::R_REQ;
                    end
                end
                icache_pkg::R_LAST: begin
                    rf.ack <= 1'b1;  // Line complete
                    state  <= icache_pkg::R_ACK;
                end
                icache_pkg::R_ACK: begin
                    if (!rf.req) begin
                        rf.ack <= 1'b0;
                        state  <= icache_pkg::R_IDLE;
                    end
                end
                default: state <= icache_pkg::R_IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (state == icache_pkg::R_REQ && mem_ack) begin
            line_buf[cnt] <= mem_data;
        end
    end

endmodule

`default_nettype wire

// ==== design/icache_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "icache_cfg.svh"

module icache_ctrl (
    input  logic                      Clk,
    input  logic                      rst_n,
    input  logic                      flush,
    input  logic                      fetch_req,
    input  logic [`ICACHE_ADDR_W-1:0] fetch_addr,
    output logic                      fetch_ack,
    output icache_pkg::word_t         fetch_data,
    output icache_pkg::set_idx_t      tag_addr,
    output logic                      tag_we,
    output icache_pkg::tag_set_t      tag_wdata,
    input  icache_pkg::tag_set_t      tag_rdata,
    output icache_pkg::set_idx_t      data_addr,
    output logic                      data_we,
    output icache_pkg::data_set_t     data_wdata,
    input  icache_pkg::data_set_t     data_rdata,
    refill_if.ctrl                    rf
);

    icache_pkg::ctrl_state_t   state;
    logic [`ICACHE_ADDR_W-1:0] addr_q;
    logic                      rd_done;     // RAM outputs belong to addr_q
    logic                      flush_pend;
    icache_pkg::set_idx_t      flush_idx;
    icache_pkg::way_t          rr_ptr [`ICACHE_NUM_SETS];
    icache_pkg::way_t          victim_q;
    logic                      evict_q;

    icache_pkg::tag_t          req_tag;
    icache_pkg::set_idx_t      req_set;
    icache_pkg::word_idx_t     req_word;
    logic                      hit;
    icache_pkg::way_t          hit_way;
    logic                      has_free;
    icache_pkg::way_t          free_way;

    assign req_tag  = addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign req_set  = addr_q[`ICACHE_OFFS_W +: `ICACHE_SET_W];
    assign req_word = addr_q[`ICACHE_BYTE_W +: `ICACHE_WORD_IDX_W];

    assign rf.line_addr = {addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFS_W], {(`ICACHE_OFFS_W){1'b0}}};

    // Flush walks the tag RAM, otherwise both RAMs follow the latched set
    assign tag_addr  = (state == icache_pkg::FLUSH) ? flush_idx : req_set;
    assign data_addr = req_set;
    assign tag_we    = (state == icache_pkg::FILL) || (state == icache_pkg::FLUSH);
    assign data_we   = (state == icache_pkg::FILL);

    // Tag compare over all ways; lowest way wins
    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        has_free = 1'b0;
        free_way = '0;
        for (int w = `ICACHE_NUM_WAYS - 1; w >= 0; w--) begin
            if (tag_rdata[w].valid && tag_rdata[w].tag == req_tag) begin
                hit     = 1'b1;
                hit_way = icache_pkg::way_t'(w);
            end
            if (!tag_rdata[w].valid) begin
                has_free = 1'b1;
                free_way = icache_pkg::way_t'(w);
            end
        end
    end

    // Read-modify-write of the set, only the victim way changes
    always_comb begin
        tag_wdata  = tag_rdata;
        data_wdata = data_rdata;
        if (state == icache_pkg::FLUSH) begin
            tag_wdata = '0;
        end else begin
            tag_wdata[victim_q].valid = 1'b1;
            tag_wdata[victim_q].tag   = req_tag;
            data_wdata[victim_q]      = rf.line;  // Valid while rf.ack is high
        end
    end

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            state      <= icache_pkg::IDLE;
            fetch_ack  <= 1'b0;
            rf.req     <= 1'b0;
            rd_done    <= 1'b0;
            flush_pend <= 1'b1;  // Invalidate everything after reset
            flush_idx  <= '0;
            for (int s = 0; s < `ICACHE_NUM_SETS; s++) begin
                rr_ptr[s] <= '0;
            end
        end else begin
            case (state)
                icache_pkg::IDLE: begin
                    if (flush_pend) begin
                        flush_pend <= 1'b0;
                        flush_idx  <= '0;
                        state      <= icache_pkg::FLUSH;
                    end else if (fetch_req) begin
                        rd_done <= 1'b0;
                        state   <= icache_pkg::LOOKUP;
                    end
                end
                icache_pkg::LOOKUP: begin
                    if (!rd_done) begin
                        rd_done <= 1'b1;  // RAM read cycle
                    end else if (hit) begin
                        fetch_ack <= 1'b1;
                        state     <= icache_pkg::RESPOND;
                    end else begin
                        rf.req <= 1'b1;
                        state  <= icache_pkg::MISS;
                    end
                end
                icache_pkg::MISS: begin
                    if (rf.ack) begin
                        rf.req <= 1'b0;
                        state  <= icache_pkg::FILL;
                    end
                end
                icache_pkg::FILL: begin
                    fetch_ack <= 1'b1;
                    state     <= icache_pkg::RESPOND;
                    if (evict_q) begin
                        rr_ptr[req_set] <= rr_ptr[req_set] + 1'b1;
                    end
                end
                icache_pkg::RESPOND: begin
                    if (!fetch_req) begin
                        fetch_ack <= 1'b0;
                        state     <= icache_pkg::IDLE;
                    end
                end
                icache_pkg::FLUSH: begin
                    flush_idx <= flush_idx + 1'b1;
                    if (flush_idx == icache_pkg::set_idx_t'(`ICACHE_NUM_SETS - 1)) begin
                        state <= icache_pkg::IDLE;
                    end
                end
                default: state <= icache_pkg::IDLE;
            endcase
            // Any flush waits for the next IDLE
            if (flush) begin
                flush_pend <= 1'b1;
            end
        end
    end

    // Request address, response word and victim choice
    always_ff @(posedge Clk) begin
        if (state == icache_pkg::IDLE && fetch_req) begin
            addr_q <= fetch_addr;
        end
        if (state == icache_pkg::LOOKUP && rd_done) begin
            fetch_data <= data_rdata[hit_way][req_word];
            victim_q   <= has_free ? free_way : rr_ptr[req_set];
            evict_q    <= !has_free;
        end
        if (state == icache_pkg::FILL) begin
            fetch_data <= rf.line[req_word];  // Word straight from the refill line
        end
    end

endmodule

`default_nettype wire

// ==== design/cache_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

// Single-port set array with registered read
module cache_ram #(
    parameter type ENTRY_T = logic [31:0],
    parameter int  DEPTH   = 8
) (
    input  logic                 Clk,
    input  icache_pkg::set_idx_t addr,
    input  logic                 we,
    input  ENTRY_T               wdata,
    output ENTRY_T               rdata
);

    ENTRY_T mem [DEPTH];

    always_ff @(posedge Clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];  // Old contents on a write cycle
    end

endmodule

`default_nettype wire

// ==== design/refill_if.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "icache_cfg.svh"

// Line request from the controller to the refill engine.
// Four-phase: line_addr held while req is high, line valid while ack is high.
interface refill_if;

    logic                      req;
    logic [`ICACHE_ADDR_W-1:0] line_addr;  // Byte address, line aligned
    logic                      ack;
    icache_pkg::line_t         line;

    modport ctrl (
        output req,
        output line_addr,
        input  ack,
        input  line
    );

    modport refill (
        input  req,
        input  line_addr,
        output ack,
        output line
    );

endinterface

`default_nettype wire

// ==== design/icache_pkg.sv ====
`default_nettype none
`include "icache_cfg.svh"

package icache_pkg;

    // Fields of a fetch address, tag | set | word | byte
    typedef logic [`ICACHE_TAG_W-1:0]      tag_t;
    typedef logic [`ICACHE_SET_W-1:0]      set_idx_t;
    typedef logic [`ICACHE_WAY_W-1:0]      way_t;
    typedef logic [`ICACHE_WORD_IDX_W-1:0] word_idx_t;

    typedef logic [`ICACHE_WORD_W-1:0]       word_t;
    typedef word_t [`ICACHE_BLOCK_WORDS-1:0] line_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // One RAM word holds a whole set
    typedef tag_entry_t [`ICACHE_NUM_WAYS-1:0] tag_set_t;
    typedef line_t [`ICACHE_NUM_WAYS-1:0]      data_set_t;

    typedef enum logic [2:0] {
        IDLE, LOOKUP, MISS, FILL, RESPOND, FLUSH
    } ctrl_state_t;

    typedef enum logic [2:0] {
        R_IDLE, R_REQ, R_REL, R_LAST, R_ACK
    } refill_state_t;

endpackage

`default_nettype wire

// ==== include/icache_cfg.svh ====
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// Cache geometry
`define ICACHE_NUM_SETS    8
`define ICACHE_NUM_WAYS    4
`define ICACHE_BLOCK_WORDS 4

// Bus widths
`define ICACHE_ADDR_W 32
`define ICACHE_WORD_W 32

// Address fields, derived from the geometry
`define ICACHE_BYTE_W     ($clog2(`ICACHE_WORD_W / 8))
`define ICACHE_WORD_IDX_W ($clog2(`ICACHE_BLOCK_WORDS))
`define ICACHE_SET_W      ($clog2(`ICACHE_NUM_SETS))
`define ICACHE_WAY_W      ($clog2(`ICACHE_NUM_WAYS))
`define ICACHE_OFFS_W     (`ICACHE_BYTE_W + `ICACHE_WORD_IDX_W)
`define ICACHE_TAG_W      (`ICACHE_ADDR_W - `ICACHE_SET_W - `ICACHE_OFFS_W)

`endif
